/* rtl/lcd_timing_pkg.sv */
package lcd_timing_pkg;

	// raster position on either axis.
	typedef logic [15:0] coord_t;

	// panel control lines.
	// hsync and vsync are active low, den is high on visible pixels.
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic den;
	} lcd_sync_t;

endpackage

/* rtl/frame_pkg.sv */
package frame_pkg;

	// one greyscale sample of the 8x8 image.
	typedef logic [7:0] grey_t;

	// {row[2:0], col[2:0]}.
	typedef logic [5:0] img_addr_t;

	// panel colour word.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_COPY,
		LOAD_DONE
	} loader_state_t;

endpackage

/* rtl/lcd_timing.sv */
`timescale 1ns/1ns

module lcd_timing #(
	parameter int H_ACTIVE = 64,
	parameter int H_FRONT  = 4,
	parameter int H_SYNC   = 4,
	parameter int H_BACK   = 8,
	parameter int V_ACTIVE = 40,
	parameter int V_FRONT  = 2,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 4
) (
	input  logic                      pixel_clk,
	input  logic                      rst,
	output lcd_timing_pkg::coord_t    x,
	output lcd_timing_pkg::coord_t    y,
	output lcd_timing_pkg::lcd_sync_t sync
);

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	lcd_timing_pkg::coord_t    h_next;
	lcd_timing_pkg::coord_t    v_next;
	lcd_timing_pkg::lcd_sync_t sync_next;

	always_comb begin
		h_next = x + 16'd1;
		v_next = y;
		if (x == H_TOTAL - 1) begin
			h_next = '0;
			v_next = (y == V_TOTAL - 1) ? '0 : y + 16'd1;
		end
	end

	// decode from the next position so sync lines up with x and y.
	always_comb begin
		sync_next.hsync = !(h_next >= H_SYNC_START && h_next < H_SYNC_START + H_SYNC);
		sync_next.vsync = !(v_next >= V_SYNC_START && v_next < V_SYNC_START + V_SYNC);
		sync_next.den   = (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
	end

	// parked on the last pixel of the frame, so the first step lands on 0,0.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			x    <= lcd_timing_pkg::coord_t'(H_TOTAL - 1);
			y    <= lcd_timing_pkg::coord_t'(V_TOTAL - 1);
			sync <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
		end else begin
			x    <= h_next;
			y    <= v_next;
			sync <= sync_next;
		end
	end

endmodule

/* rtl/image_rom.sv */
`timescale 1ns/1ns

module image_rom (
	input  logic                  pixel_clk,
	input  frame_pkg::img_addr_t  addr,
	output frame_pkg::grey_t      data
);

	frame_pkg::grey_t mem [0:63];

	// row-major 8x8 image.
	initial begin
		$readmemh("image.hex", mem);
	end

	always_ff @(posedge pixel_clk) begin
		data <= mem[addr]; // one clock read latency.
	end

endmodule

/* rtl/frame_loader.sv */
`timescale 1ns/1ns

module frame_loader (
	input  logic                 pixel_clk,
	input  logic                 rst,
	output frame_pkg::img_addr_t rom_addr,
	output logic                 wr_en,
	output frame_pkg::img_addr_t wr_addr,
	output logic                 loaded
);

	frame_pkg::loader_state_t state;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			state    <= frame_pkg::LOAD_IDLE;
			rom_addr <= '0;
			wr_en    <= 1'b0;
			loaded   <= 1'b0;
		end else begin
			wr_en <= (state == frame_pkg::LOAD_COPY); // rom data shows up next clock.
			case (state)
				frame_pkg::LOAD_IDLE: begin
					state <= frame_pkg::LOAD_COPY;
				end
				frame_pkg::LOAD_COPY: begin
					rom_addr <= rom_addr + 6'd1;
					if (rom_addr == 6'd63) begin
						state <= frame_pkg::LOAD_DONE;
					end
				end
				frame_pkg::LOAD_DONE: begin
					loaded <= 1'b1; // same edge as the last write.
				end
				default: begin
					state <= frame_pkg::LOAD_IDLE;
				end
			endcase
		end
	end

	// follows rom_addr by the rom latency.
	always_ff @(posedge pixel_clk) begin
		wr_addr <= rom_addr;
	end

endmodule

/* rtl/video_ram.sv */
`timescale 1ns/1ns

module video_ram (
	input  logic                 pixel_clk,
	input  logic                 wr_en,
	input  frame_pkg::img_addr_t wr_addr,
	input  frame_pkg::grey_t     wr_data,
	input  logic                 rd_en,
	input  frame_pkg::img_addr_t rd_addr,
	output frame_pkg::grey_t     rd_data
);

	frame_pkg::grey_t mem [0:63];

	always_ff @(posedge pixel_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read register holds while rd_en is low.
	always_ff @(posedge pixel_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* rtl/pixel_mixer.sv */
`timescale 1ns/1ns

module pixel_mixer #(
	parameter int WIN_X = 16,
	parameter int WIN_Y = 4
) (
	input  logic                      pixel_clk,
	input  logic                      rst,
	input  lcd_timing_pkg::coord_t    x,
	input  lcd_timing_pkg::coord_t    y,
	input  lcd_timing_pkg::lcd_sync_t sync_in,
	output frame_pkg::img_addr_t      rd_addr,
	input  frame_pkg::grey_t          rd_data,
	output lcd_timing_pkg::lcd_sync_t lcd_sync,
	output frame_pkg::rgb565_t        lcd_pixel
);

	// 8 samples at scale 4.
	localparam int WIN_SIZE = 32;

	lcd_timing_pkg::coord_t    col_off;
	lcd_timing_pkg::coord_t    row_off;
	logic                      in_win;
	logic                      in_win_d;
	lcd_timing_pkg::coord_t    sum_d;
	lcd_timing_pkg::lcd_sync_t sync_d;
	logic [15:0]               colour;

	assign col_off = x - lcd_timing_pkg::coord_t'(WIN_X);
	assign row_off = y - lcd_timing_pkg::coord_t'(WIN_Y);
	assign rd_addr = {row_off[4:2], col_off[4:2]}; // divide by the scale.

	assign in_win = (x >= WIN_X) && (x < WIN_X + WIN_SIZE) &&
		(y >= WIN_Y) && (y < WIN_Y + WIN_SIZE);

	// stage 1 runs alongside the ram read.
	always_ff @(posedge pixel_clk) begin
		in_win_d <= in_win;
		sum_d    <= x + y;
	end

	assign colour = in_win_d ? {rd_data, rd_data} : sum_d;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			sync_d    <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
			lcd_sync  <= '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
			lcd_pixel <= '0;
		end else begin
			sync_d   <= sync_in;
			lcd_sync <= sync_d;
			if (sync_d.den) begin
				// low bits feed every channel, as the panel wiring expects.
				lcd_pixel <= '{r: colour[4:0], g: colour[5:0], b: colour[4:0]};
			end else begin
				lcd_pixel <= '0; // blank outside the active area.
			end
		end
	end

endmodule

/* rtl/lcd_subsystem.sv */
`timescale 1ns/1ns

module lcd_subsystem #(
	parameter int H_ACTIVE = 64,
	parameter int H_FRONT  = 4,
	parameter int H_SYNC   = 4,
	parameter int H_BACK   = 8,
	parameter int V_ACTIVE = 40,
	parameter int V_FRONT  = 2,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 4,
	parameter int WIN_X    = 16,
	parameter int WIN_Y    = 4
) (
	input  logic                      pixel_clk,
	input  logic                      rst,
	input  logic                      freeze,
	output lcd_timing_pkg::lcd_sync_t lcd_sync,
	output frame_pkg::rgb565_t        lcd_pixel,
	output logic                      loaded
);

	lcd_timing_pkg::coord_t    x;
	lcd_timing_pkg::coord_t    y;
	lcd_timing_pkg::lcd_sync_t timing_sync;
	frame_pkg::img_addr_t      rom_addr;
	frame_pkg::grey_t          rom_data;
	logic                      wr_en;
	frame_pkg::img_addr_t      wr_addr;
	logic                      rd_en;
	frame_pkg::img_addr_t      rd_addr;
	frame_pkg::grey_t          rd_data;

	assign rd_en = ~freeze; // freeze stalls the ram read register.

	lcd_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) lcd_timing_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.sync      (timing_sync)
	);

	image_rom image_rom_i (
		.pixel_clk (pixel_clk),
		.addr      (rom_addr),
		.data      (rom_data)
	);

	frame_loader frame_loader_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.rom_addr  (rom_addr),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.loaded    (loaded)
	);

	video_ram video_ram_i (
		.pixel_clk (pixel_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (rom_data),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	pixel_mixer #(
		.WIN_X (WIN_X),
		.WIN_Y (WIN_Y)
	) pixel_mixer_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.sync_in   (timing_sync),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.lcd_sync  (lcd_sync),
		.lcd_pixel (lcd_pixel)
	);

endmodule

/* testbench/tb_lcd_subsystem.sv */
`timescale 1ns/1ns

module tb_lcd_subsystem;

	localparam int H_ACTIVE     = 64;
	localparam int H_FRONT      = 4;
	localparam int H_SYNC       = 4;
	localparam int H_BACK       = 8;
	localparam int V_ACTIVE     = 40;
	localparam int V_FRONT      = 2;
	localparam int V_SYNC       = 2;
	localparam int V_BACK       = 4;
	localparam int WIN_X        = 16;
	localparam int WIN_Y        = 4;
	localparam int WIN_SIZE     = 32;
	localparam int LINE_CLOCKS  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	localparam int RESET_CYCLES = 10;
	localparam int LOAD_CYCLES  = 65;
	localparam int LOAD_LIMIT   = 100;
	localparam int ENTRIES      = 5;
	localparam int RUN_FRAMES   = 10; // seven table frames, the lead-in frame and slack.
	localparam int MAX_CYCLES   = RUN_FRAMES * FRAME_CLOCKS + LOAD_CYCLES + 200;

	typedef struct packed {
		logic       freeze;
		logic [3:0] frames;
	} stim_t;

	logic                      pixel_clk;
	logic                      rst;
	logic                      freeze;
	lcd_timing_pkg::lcd_sync_t lcd_sync;
	frame_pkg::rgb565_t        lcd_pixel;
	logic                      loaded;

	frame_pkg::grey_t          img [0:63];
	stim_t                     stim_table [ENTRIES];
	int                        cycle_count = 0;
	int                        since_release;
	lcd_timing_pkg::lcd_sync_t prev_sync;
	logic                      prev_loaded;
	logic                      synced;
	logic                      checking;
	logic                      frame_frozen;
	logic                      frame_start;
	frame_pkg::grey_t          hold_val;
	int                        den_run;
	int                        line_y;
	int                        since_den_fall;
	logic                      gap_valid;
	int                        hs_low_run;
	int                        vs_low_run;
	int                        window_px;
	int                        frozen_px;

	lcd_subsystem #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK),
		.WIN_X    (WIN_X),
		.WIN_Y    (WIN_Y)
	) lcd_subsystem_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.freeze    (freeze),
		.lcd_sync  (lcd_sync),
		.lcd_pixel (lcd_pixel),
		.loaded    (loaded)
	);

	always #2 pixel_clk = ~pixel_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic in_window(input int px, input int py);
		return px >= WIN_X && px < WIN_X + WIN_SIZE && py >= WIN_Y && py < WIN_Y + WIN_SIZE;
	endfunction

	// window offset divided by four and wrapped to 3-bit row and column.
	function automatic int read_addr(input int px, input int py);
		int row;
		int col;
		row = ((py - WIN_Y) >>> 2) & 7;
		col = ((px - WIN_X) >>> 2) & 7;
		return row * 8 + col;
	endfunction

	function automatic frame_pkg::rgb565_t expected_pixel(input int px, input int py);
		frame_pkg::grey_t   sample;
		logic [15:0]        colour;
		frame_pkg::rgb565_t pix;
		colour = 16'(px + py);
		if (in_window(px, py)) begin
			sample = frame_frozen ? hold_val : img[read_addr(px, py)];
			colour = {sample, sample};
		end
		pix.r = colour[4:0];
		pix.g = colour[5:0];
		pix.b = colour[4:0];
		return pix;
	endfunction

	task check_reset_values();
		check_equal("lcd_sync.hsync", lcd_sync.hsync, 1);
		check_equal("lcd_sync.vsync", lcd_sync.vsync, 1);
		check_equal("lcd_sync.den", lcd_sync.den, 0);
		check_equal("lcd_pixel", lcd_pixel, 0);
		check_equal("loaded", loaded, 0);
	endtask

	// one clock of the output model with position, raster and pixel checks.
	task step_clock();
		lcd_timing_pkg::lcd_sync_t s;
		frame_pkg::rgb565_t        p;
		@(posedge pixel_clk);
		s = lcd_sync;
		p = lcd_pixel;
		since_release++;
		frame_start = 1'b0;
		if (prev_loaded && !loaded) abort_run("loaded fell after it had risen");
		if (!loaded && since_release > LOAD_LIMIT)
			abort_run("loaded did not rise within 100 cycles of reset release");
		if (prev_sync.vsync && !s.vsync) begin
			if (synced) check_equal("active lines per frame", line_y, V_ACTIVE);
			vs_low_run = 0;
		end
		if (!s.vsync) vs_low_run++;
		if (!prev_sync.vsync && s.vsync) begin
			check_equal("vsync low clocks", vs_low_run, V_SYNC * LINE_CLOCKS);
			synced = 1'b1;
			line_y = 0; // first den line after this is row 0.
		end
		if (prev_sync.den && !s.den) begin
			since_den_fall = 0;
			gap_valid = 1'b1;
		end else begin
			since_den_fall++;
		end
		if (prev_sync.hsync && !s.hsync) begin
			if (gap_valid) check_equal("hsync start after den", since_den_fall, H_FRONT);
			gap_valid = 1'b0;
			hs_low_run = 0;
		end
		if (!s.hsync) hs_low_run++;
		if (!prev_sync.hsync && s.hsync) check_equal("hsync low clocks", hs_low_run, H_SYNC);
		if (s.den) begin
			if (den_run == 0 && synced && line_y == 0) frame_start = 1'b1;
			if (checking) begin
				check_equal($sformatf("lcd_pixel at x=%0d y=%0d", den_run, line_y), p,
					expected_pixel(den_run, line_y));
				if (in_window(den_run, line_y)) begin
					window_px++;
					if (frame_frozen) frozen_px++;
				end
			end
			den_run++;
		end else begin
			if (prev_sync.den) begin
				check_equal("den clocks per line", den_run, H_ACTIVE);
				line_y++;
			end
			den_run = 0;
			check_equal("lcd_pixel in blanking", p, 0);
		end
		prev_sync = s;
		prev_loaded = loaded;
	endtask

	task wait_frame_start();
		do begin
			step_clock();
		end while (!frame_start);
	endtask

	always @(posedge pixel_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) abort_run("timeout, the run took too many cycles");
	end

	initial begin
		int total_frames;
		int frozen_frames;
		pixel_clk = 1'b0;
		rst = 1'b0;
		freeze = 1'b0;
		prev_sync = '{hsync: 1'b1, vsync: 1'b1, den: 1'b0};
		prev_loaded = 1'b0;
		{synced, checking, frame_frozen, frame_start, gap_valid} = '0;
		{since_release, den_run, line_y, since_den_fall} = '0;
		{hs_low_run, vs_low_run, window_px, frozen_px} = '0;
		hold_val = '0;
		total_frames = 0;
		frozen_frames = 0;
		$readmemh("image.hex", img);
		stim_table[0] = '{freeze: 1'b0, frames: 4'd2};
		stim_table[1] = '{freeze: 1'b1, frames: 4'd1};
		stim_table[2] = '{freeze: 1'b0, frames: 4'd1}; // thaw.
		stim_table[3] = '{freeze: 1'b1, frames: 4'd2};
		stim_table[4] = '{freeze: 1'b0, frames: 4'd1};
		@(posedge pixel_clk);
		repeat (RESET_CYCLES - 1) begin
			@(posedge pixel_clk);
			check_reset_values();
		end
		rst <= 1'b1;
		// lead-in frame runs while the loader fills the ram.
		do begin
			step_clock();
		end while (!(frame_start && loaded));
		checking = 1'b1;
		for (int i = 0; i < ENTRIES; i++) begin
			for (int f = 0; f < stim_table[i].frames; f++) begin
				freeze <= stim_table[i].freeze;
				// last read before freeze lands is pixel (2,0).
				if (stim_table[i].freeze && !frame_frozen) hold_val = img[read_addr(2, 0)];
				frame_frozen = stim_table[i].freeze;
				total_frames++;
				if (frame_frozen) frozen_frames++;
				wait_frame_start();
			end
		end
		if (window_px == total_frames * WIN_SIZE * WIN_SIZE &&
			frozen_px == frozen_frames * WIN_SIZE * WIN_SIZE) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("not every window pixel of the table frames was checked");
		end
	end

endmodule

/* project.f */
rtl/lcd_timing_pkg.sv
rtl/frame_pkg.sv
rtl/lcd_timing.sv
rtl/image_rom.sv
rtl/frame_loader.sv
rtl/video_ram.sv
rtl/pixel_mixer.sv
rtl/lcd_subsystem.sv
testbench/tb_lcd_subsystem.sv

/* image.hex */
// 8x8 greyscale image, one byte per line, row-major (row 0 col 0 first)
05
10
1b
26
31
3c
47
52
2a
35
40
4b
56
61
6c
77
4f
5a
65
70
7b
86
91
9c
74
7f
8a
95
a0
ab
b6
c1
99
a4
af
ba
c5
d0
db
e6
be
c9
d4
df
ea
f5
00
0b
e3
ee
f9
04
0f
1a
25
30
08
13
1e
29
34
3f
4a
55
